// File: source/des_config.svh
`ifndef DES_CONFIG_SVH
`define DES_CONFIG_SVH

// block, key and half-block widths.
`define DES_BLOCK_W  64
`define DES_KEY_W    64
`define DES_HALF_W   32

// key after permuted choice 1, and one round key.
`define DES_CD_W     56
`define DES_SUBKEY_W 48

// round count and round counter width.
`define DES_ROUNDS   16
`define DES_ROUND_W  4

`endif

// File: source/des_pkg.sv
`include "des_config.svh"

package des_pkg;

    typedef logic [`DES_BLOCK_W-1:0]  block_t;
    typedef logic [`DES_CD_W-1:0]     cd_t;
    typedef logic [`DES_HALF_W-1:0]   half_t;
    typedef logic [`DES_SUBKEY_W-1:0] subkey_t;
    typedef logic [`DES_ROUND_W-1:0]  round_t;

    typedef enum logic {
        op_encrypt = 1'b0,
        op_decrypt = 1'b1
    } des_op_e;

    typedef enum logic {
        st_idle = 1'b0,
        st_run  = 1'b1
    } ctrl_state_e;

    localparam int CD_HALF = `DES_CD_W / 2;

    // ########################################################################
    // permutation tables, bit 1 is the msb as in the standard.
    // ########################################################################

    localparam byte unsigned IP_TAB [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

    localparam byte unsigned FP_TAB [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25};

    localparam byte unsigned PC1_TAB [56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4};

    localparam byte unsigned PC2_TAB [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

    localparam byte unsigned E_TAB [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1};

    localparam byte unsigned P_TAB [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25};

    // one row of 16 per line, four rows per box.
    localparam logic [3:0] SBOX_TAB [8][64] = '{
        '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
           0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
           4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
          15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
        '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
           3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
           0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
          13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
        '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
          13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
          13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
           1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
        '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
          13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
          10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
           3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
        '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
          14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
           4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
          11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
        '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
          10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
           9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
           4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
        '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
          13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
           1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
           6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
        '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
           1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
           7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
           2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}};

    // ########################################################################
    // table functions.
    // ########################################################################

    function automatic block_t ip(block_t b);
        block_t r;
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            r[`DES_BLOCK_W-1-i] = b[`DES_BLOCK_W - IP_TAB[i]];
        end
        return r;
    endfunction

    function automatic block_t fp(block_t b);
        block_t r;
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            r[`DES_BLOCK_W-1-i] = b[`DES_BLOCK_W - FP_TAB[i]];
        end
        return r;
    endfunction

    // parity bits 8, 16 .. 64 are dropped here.
    function automatic cd_t pc1(logic [`DES_KEY_W-1:0] k);
        cd_t r;
        for (int i = 0; i < `DES_CD_W; i++) begin
            r[`DES_CD_W-1-i] = k[`DES_KEY_W - PC1_TAB[i]];
        end
        return r;
    endfunction

    function automatic subkey_t pc2(cd_t cd);
        subkey_t r;
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            r[`DES_SUBKEY_W-1-i] = cd[`DES_CD_W - PC2_TAB[i]];
        end
        return r;
    endfunction

    function automatic subkey_t expand(half_t h);
        subkey_t r;
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            r[`DES_SUBKEY_W-1-i] = h[`DES_HALF_W - E_TAB[i]];
        end
        return r;
    endfunction

    function automatic half_t pperm(half_t h);
        half_t r;
        for (int i = 0; i < `DES_HALF_W; i++) begin
            r[`DES_HALF_W-1-i] = h[`DES_HALF_W - P_TAB[i]];
        end
        return r;
    endfunction

    // row from the outer bits, column from the inner four.
    function automatic logic [3:0] sbox(logic [2:0] num, logic [5:0] x);
        return SBOX_TAB[num][{x[5], x[0], x[4:1]}];
    endfunction

    function automatic logic [1:0] shift_amount(logic [4:0] round_num);
        if (round_num == 5'd1 || round_num == 5'd2 || round_num == 5'd9 ||
            round_num == 5'd16) begin
            return 2'd1;
        end
        return 2'd2;
    endfunction

    // rotates C and D separately.
    function automatic cd_t cd_rotate(cd_t cd, logic [1:0] amt, logic right);
        logic [CD_HALF-1:0] c;
        logic [CD_HALF-1:0] d;
        c = cd[`DES_CD_W-1:CD_HALF];
        d = cd[CD_HALF-1:0];
        for (int i = 0; i < 2; i++) begin
            if (i < int'(amt)) begin
                if (right) begin
                    c = {c[0], c[CD_HALF-1:1]};
                    d = {d[0], d[CD_HALF-1:1]};
                end else begin
                    c = {c[CD_HALF-2:0], c[CD_HALF-1]};
                    d = {d[CD_HALF-2:0], d[CD_HALF-1]};
                end
            end
        end
        return {c, d};
    endfunction

endpackage

// File: source/des_ctrl_if.sv
interface des_ctrl_if import des_pkg::*; ();

    logic   key_wr;
    logic   load;
    logic   round_en;
    logic   decrypt;
    round_t round;

    modport control (
        output key_wr, load, round_en, decrypt, round
    );

    modport schedule (
        input key_wr, load, round_en, decrypt, round
    );

    modport datapath (
        input load, round_en
    );

endinterface

// File: source/des_control.sv
`include "des_config.svh"

module des_control import des_pkg::*; (
    input  logic        ck,
    input  logic        rst_n,
    input  logic        key_load,
    input  logic        start,
    input  des_op_e     op,
    output logic        busy,
    output logic        done,
    des_ctrl_if.control ctrl
);

    localparam round_t ROUND_LAST = round_t'(`DES_ROUNDS - 1);

    ctrl_state_e state;
    round_t      round_q;
    des_op_e     op_q;
    logic        idle;

    assign idle = (state == st_idle);
    assign busy = !idle;

    // both strobes are dropped while a block is in flight.
    assign ctrl.key_wr   = key_load && idle;
    assign ctrl.load     = start && idle;
    assign ctrl.round_en = !idle;
    assign ctrl.round    = round_q;

    // the key schedule needs the direction already in the load cycle.
    assign ctrl.decrypt = idle ? (op == op_decrypt) : (op_q == op_decrypt);

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            state   <= st_idle;
            round_q <= '0;
            op_q    <= op_encrypt;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (ctrl.load) begin
                        state   <= st_run;
                        round_q <= '0;
                        op_q    <= op;
                    end
                end
                st_run: begin
                    round_q <= round_q + 1'b1;
                    if (round_q == ROUND_LAST) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: source/des_key_schedule.sv
`include "des_config.svh"

module des_key_schedule import des_pkg::*; (
    input  logic         ck,
    input  logic         rst_n,
    input  block_t       key,
    des_ctrl_if.schedule ctrl,
    output subkey_t      subkey
);

    cd_t        key_cd;
    cd_t        work_cd;
    logic [4:0] next_round;
    logic [1:0] amt;

    // rotation that takes the working key to the next round's key.
    always_comb begin
        if (ctrl.decrypt) begin
            next_round = 5'(`DES_ROUNDS) - {1'b0, ctrl.round};
        end else begin
            next_round = {1'b0, ctrl.round} + 5'd2;
        end
        amt = shift_amount(next_round);
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            key_cd <= '0;
        end else if (ctrl.key_wr) begin
            key_cd <= pc1(key);
        end
    end

    // the 16 encryption rotations sum to 28, so the last round key of
    // encryption is the stored key itself.
    always_ff @(posedge ck) begin
        if (ctrl.load) begin
            if (ctrl.decrypt) begin
                work_cd <= key_cd;
            end else begin
                work_cd <= cd_rotate(key_cd, 2'd1, 1'b0);
            end
        end else if (ctrl.round_en) begin
            work_cd <= cd_rotate(work_cd, amt, ctrl.decrypt);
        end
    end

    assign subkey = pc2(work_cd);

endmodule

// File: source/des_datapath.sv
module des_datapath import des_pkg::*; (
    input  logic         ck,
    input  logic         rst_n,
    input  block_t       block_in,
    input  subkey_t      subkey,
    des_ctrl_if.datapath ctrl,
    output block_t       block_out
);

    half_t   l_q;
    half_t   r_q;
    half_t   l_next;
    half_t   r_next;
    subkey_t mixed;
    half_t   s_out;
    block_t  ip_blk;

    assign ip_blk = ip(block_in);

    // ########################################################################
    // feistel round.
    // ########################################################################

    always_comb begin
        mixed = expand(r_q) ^ subkey;
        for (int i = 0; i < 8; i++) begin
            s_out[31-4*i -: 4] = sbox(3'(i), mixed[47-6*i -: 6]);
        end
        l_next = r_q;
        r_next = l_q ^ pperm(s_out);
    end

    always_ff @(posedge ck) begin
        if (ctrl.load) begin
            l_q <= ip_blk[63:32];
            r_q <= ip_blk[31:0];
        end else if (ctrl.round_en) begin
            l_q <= l_next;
            r_q <= r_next;
        end
    end

    // halves swap before the final permutation.
    // the last round_en leaves the finished block here.
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            block_out <= '0;
        end else if (ctrl.round_en) begin
            block_out <= fp({r_next, l_next});
        end
    end

endmodule

// File: source/des_core.sv
module des_core import des_pkg::*; (
    input  logic    ck,
    input  logic    rst_n,
    input  logic    key_load,
    input  block_t  key,
    input  logic    start,
    input  des_op_e op,
    input  block_t  block_in,
    output block_t  block_out,
    output logic    done,
    output logic    busy
);

    subkey_t subkey;

    des_ctrl_if ctrl_bus ();

    des_control i_des_control (
        .ck       (ck),
        .rst_n    (rst_n),
        .key_load (key_load),
        .start    (start),
        .op       (op),
        .busy     (busy),
        .done     (done),
        .ctrl     (ctrl_bus.control)
    );

    des_key_schedule i_des_key_schedule (
        .ck     (ck),
        .rst_n  (rst_n),
        .key    (key),
        .ctrl   (ctrl_bus.schedule),
        .subkey (subkey)
    );

    // one round circuit, reused for all sixteen rounds.
    des_datapath i_des_datapath (
        .ck        (ck),
        .rst_n     (rst_n),
        .block_in  (block_in),
        .subkey    (subkey),
        .ctrl      (ctrl_bus.datapath),
        .block_out (block_out)
    );

endmodule

// File: tests/des_tb.sv
module des_tb import des_pkg::*; ();

    localparam int NUM_VEC        = 4;
    localparam int LATENCY        = 16;
    localparam int TIMEOUT_CYCLES = 40;
    localparam int NUM_RANDOM     = 20;

    // ########################################################################
    // known answer vectors, one row per index.
    // rows 1 and 3 share a key.
    // ########################################################################

    localparam block_t KEY_TAB [NUM_VEC] = '{
        64'h133457799BBCDFF1, 64'h0E329232EA6D0D73,
        64'h0000000000000000, 64'h0E329232EA6D0D73};

    localparam block_t PLAIN_TAB [NUM_VEC] = '{
        64'h0123456789ABCDEF, 64'h8787878787878787,
        64'h0000000000000000, 64'h596F7572206C6970};

    localparam block_t CIPHER_TAB [NUM_VEC] = '{
        64'h85E813540F0AB405, 64'h0000000000000000,
        64'h8CA64DE9C1B123A7, 64'hC0999FDDE378D7ED};

    logic    ck;
    logic    rst_n;
    logic    key_load;
    block_t  key;
    logic    start;
    des_op_e op;
    block_t  block_in;
    block_t  block_out;
    logic    done;
    logic    busy;

    block_t  result;
    block_t  rnd_key;
    block_t  rnd_blk;

    des_core i_des_core (
        .ck        (ck),
        .rst_n     (rst_n),
        .key_load  (key_load),
        .key       (key),
        .start     (start),
        .op        (op),
        .block_in  (block_in),
        .block_out (block_out),
        .done      (done),
        .busy      (busy)
    );

    always #10 ck = ~ck;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            report_failure($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // inputs change shortly after the rising edge.
    task automatic step_cycle();
        @(posedge ck);
        #2;
    endtask

    task automatic load_key(input block_t k);
        key_load = 1'b1;
        key      = k;
        step_cycle();
        key_load = 1'b0;
    endtask

    task automatic start_block(input des_op_e o, input block_t b);
        start    = 1'b1;
        op       = o;
        block_in = b;
        step_cycle();
        start    = 1'b0;
    endtask

    // counts cycles from the start edge until done.
    task automatic wait_done(input logic disturb, output block_t res);
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                report_failure("timeout: no done pulse within the cycle limit after start");
            end
            check_value("busy", 64'(busy), 64'd1);
            // a mid-block start and key write, which the core must drop.
            if (disturb && cycles == 4) begin
                start    = 1'b1;
                block_in = ~block_in;
                op       = (op == op_encrypt) ? op_decrypt : op_encrypt;
                key_load = 1'b1;
                key      = ~key;
            end else begin
                start    = 1'b0;
                key_load = 1'b0;
            end
            step_cycle();
            cycles++;
        end
        start    = 1'b0;
        key_load = 1'b0;
        check_value("done latency", 64'(cycles), 64'(LATENCY));
        check_value("busy", 64'(busy), 64'd0);
        res = block_out;
    endtask

    task automatic run_block(input des_op_e o, input block_t b, input block_t exp,
                             input logic disturb);
        block_t res;
        start_block(o, b);
        wait_done(disturb, res);
        check_value("block_out", res, exp);
    endtask

    initial begin
        void'($urandom(23));
        ck       = 1'b0;
        rst_n    = 1'b0;
        key_load = 1'b0;
        key      = '0;
        start    = 1'b0;
        op       = op_encrypt;
        block_in = '0;

        repeat (4) @(posedge ck);
        #2;
        rst_n = 1'b1;
        check_value("busy", 64'(busy), 64'd0);
        check_value("done", 64'(done), 64'd0);
        check_value("block_out", block_out, 64'd0);

        for (int i = 0; i < NUM_VEC; i++) begin
            load_key(KEY_TAB[i]);
            run_block(op_encrypt, PLAIN_TAB[i], CIPHER_TAB[i], 1'b0);
        end

        for (int i = 0; i < NUM_VEC; i++) begin
            load_key(KEY_TAB[i]);
            run_block(op_decrypt, CIPHER_TAB[i], PLAIN_TAB[i], 1'b0);
        end

        // second start lands in the done cycle of the first block.
        load_key(KEY_TAB[1]);
        start_block(op_encrypt, PLAIN_TAB[1]);
        wait_done(1'b0, result);
        check_value("block_out", result, CIPHER_TAB[1]);
        run_block(op_encrypt, PLAIN_TAB[3], CIPHER_TAB[3], 1'b0);

        load_key(KEY_TAB[0]);
        run_block(op_encrypt, PLAIN_TAB[0], CIPHER_TAB[0], 1'b1);
        run_block(op_decrypt, CIPHER_TAB[0], PLAIN_TAB[0], 1'b0);

        // done is a single pulse and the result stays put.
        for (int n = 0; n < 3; n++) begin
            step_cycle();
            check_value("done", 64'(done), 64'd0);
            check_value("busy", 64'(busy), 64'd0);
            check_value("block_out", block_out, PLAIN_TAB[0]);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd_key = {$urandom, $urandom};
            rnd_blk = {$urandom, $urandom};
            load_key(rnd_key);
            start_block(op_encrypt, rnd_blk);
            wait_done(1'b0, result);
            run_block(op_decrypt, result, rnd_blk, 1'b0);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: des.f
+incdir+source
source/des_pkg.sv
source/des_ctrl_if.sv
source/des_control.sv
source/des_key_schedule.sv
source/des_datapath.sv
source/des_core.sv
tests/des_tb.sv

// File: Makefile
SIM = obj_dir/des_sim

.PHONY: all lint clean

all: $(SIM)
	./$(SIM)

$(SIM): des.f source/des_config.svh source/*.sv tests/des_tb.sv
	verilator --binary --timing --assert -f des.f --top-module des_tb -o des_sim

lint:
	verilator --lint-only --timing -Wall -f des.f --top-module des_core

clean:
	rm -rf obj_dir
